/* hdl/fm_mixer_config.svh */
`ifndef FM_MIXER_CONFIG_SVH
`define FM_MIXER_CONFIG_SVH

// voices sharing the slot pipeline
`define FM_VOICES 4

// oscillators per voice
`define FM_V_OSC 4

// stereo channel width
`define FM_AUD_DEPTH 24

// slots per frame, voice-major order
`define FM_SLOTS (`FM_VOICES * `FM_V_OSC)

`endif

/* hdl/fm_mixer_pkg.sv */
`default_nettype none

`include "fm_mixer_config.svh"

package fm_mixer_pkg;

    localparam int VOICE_W = $clog2(`FM_VOICES);
    localparam int OSC_W   = $clog2(`FM_V_OSC);

    typedef logic [VOICE_W-1:0]              voice_t;
    typedef logic [OSC_W-1:0]                osc_t;
    typedef logic signed [7:0]               level_t;   // envelope level or patch register
    typedef logic signed [16:0]              sine_t;
    typedef logic signed [10:0]              mod_t;
    typedef logic signed [`FM_AUD_DEPTH-1:0] audio_t;
    typedef logic [6:0]                      reg_adr_t;

    // voice in the upper bits so a flat count runs voice-major
    typedef struct packed {
        voice_t voice;
        osc_t   osc;
    } slot_t;

    typedef struct packed {
        reg_adr_t adr;
        level_t   wr_data;
        logic     wr_stb;
        logic     rd_stb;
    } host_bus_t;

    // register map bases
    localparam reg_adr_t ADR_LVL   = 7'h00;  // one per oscillator
    localparam reg_adr_t ADR_PAN   = 7'h08;  // one per oscillator
    localparam reg_adr_t ADR_ROUTE = 7'h10;  // dest * V_OSC + src
    localparam reg_adr_t ADR_MVOL  = 7'h20;

endpackage

`default_nettype wire

/* hdl/patch_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fm_mixer_config.svh"

module patch_regs (
    input  logic                    sCLK_XVXENVS,
    input  logic                    rst_n,
    input  fm_mixer_pkg::host_bus_t host,
    output fm_mixer_pkg::level_t    rd_data,
    output fm_mixer_pkg::level_t    osc_lvl [`FM_V_OSC],
    output fm_mixer_pkg::level_t    osc_pan [`FM_V_OSC],
    output fm_mixer_pkg::level_t    route   [`FM_V_OSC*`FM_V_OSC],
    output fm_mixer_pkg::level_t    m_vol
);
    import fm_mixer_pkg::*;

    localparam int ROUTE_N = `FM_V_OSC * `FM_V_OSC;

    level_t rd_mux;
    level_t pan_clamped;

    // pan is 0..127, anything with bit 7 set pins to full right
    assign pan_clamped = host.wr_data[7] ? 8'sd127 : host.wr_data;

    always_ff @(posedge sCLK_XVXENVS) begin
        if (!rst_n) begin
            for (int i = 0; i < `FM_V_OSC; i++) begin
                osc_lvl[i] <= '0;
                osc_pan[i] <= '0;
            end
            for (int i = 0; i < ROUTE_N; i++) begin
                route[i] <= '0;
            end
            m_vol <= '0;
        end else if (host.wr_stb) begin
            for (int i = 0; i < `FM_V_OSC; i++) begin
                if (host.adr == ADR_LVL + reg_adr_t'(i)) begin
                    osc_lvl[i] <= host.wr_data;
                end
                if (host.adr == ADR_PAN + reg_adr_t'(i)) begin
                    osc_pan[i] <= pan_clamped;
                end
            end
            for (int i = 0; i < ROUTE_N; i++) begin
                if (host.adr == ADR_ROUTE + reg_adr_t'(i)) begin
                    route[i] <= host.wr_data;
                end
            end
            if (host.adr == ADR_MVOL) begin
                m_vol <= host.wr_data;
            end
        end
    end

    // read mux, holes in the map fall through to zero
    always_comb begin
        rd_mux = '0;
        for (int i = 0; i < `FM_V_OSC; i++) begin
            if (host.adr == ADR_LVL + reg_adr_t'(i)) begin
                rd_mux = osc_lvl[i];
            end
            if (host.adr == ADR_PAN + reg_adr_t'(i)) begin
                rd_mux = osc_pan[i];
            end
        end
        for (int i = 0; i < ROUTE_N; i++) begin
            if (host.adr == ADR_ROUTE + reg_adr_t'(i)) begin
                rd_mux = route[i];
            end
        end
        if (host.adr == ADR_MVOL) begin
            rd_mux = m_vol;
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (host.rd_stb) begin
            rd_data <= rd_mux;  // held until the next read
        end
    end

endmodule

`default_nettype wire

/* hdl/slot_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fm_mixer_config.svh"

module slot_sequencer (
    input  logic                sCLK_XVXENVS,
    input  logic                rst_n,
    input  logic                frame_start,
    output fm_mixer_pkg::slot_t slot_now,
    output fm_mixer_pkg::slot_t slot_d1,
    output fm_mixer_pkg::slot_t slot_d2,
    output logic                frame_end_d2
);
    import fm_mixer_pkg::*;

    localparam int CNT_W = $bits(slot_t);
    localparam int O_W   = $bits(osc_t);
    localparam logic [CNT_W-1:0] LAST_SLOT = CNT_W'(`FM_SLOTS - 1);

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_cur;
    logic [CNT_W-1:0] cnt_nxt;

    // frame_start forces slot 0 in its own cycle
    assign cnt_cur = frame_start ? '0 : cnt_q;
    assign cnt_nxt = (cnt_cur == LAST_SLOT) ? '0 : cnt_cur + CNT_W'(1);

    // voice-major split of the flat count
    assign slot_now.voice = cnt_cur[CNT_W-1:O_W];
    assign slot_now.osc   = cnt_cur[O_W-1:0];

    always_ff @(posedge sCLK_XVXENVS) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_nxt;  // wraps by itself without frame_start
        end
    end

    // index delay line, one stage per pipeline register downstream
    always_ff @(posedge sCLK_XVXENVS) begin
        if (!rst_n) begin
            slot_d1 <= '0;
            slot_d2 <= '0;
        end else begin
            slot_d1 <= slot_now;
            slot_d2 <= slot_d1;
        end
    end

    assign frame_end_d2 = (slot_d2 == LAST_SLOT);  // last slot sits in stage 2

endmodule

`default_nettype wire

/* hdl/modulation_matrix.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fm_mixer_config.svh"

module modulation_matrix (
    input  logic                 sCLK_XVXENVS,
    input  logic                 rst_n,
    input  fm_mixer_pkg::slot_t  slot_now,
    input  fm_mixer_pkg::slot_t  slot_d1,
    input  fm_mixer_pkg::level_t level_mul_vel,
    input  fm_mixer_pkg::sine_t  sine_lut_out,
    input  fm_mixer_pkg::level_t route [`FM_V_OSC*`FM_V_OSC],
    output fm_mixer_pkg::mod_t   modulation,
    output fm_mixer_pkg::slot_t  mod_slot,
    output logic                 mod_valid,
    output fm_mixer_pkg::level_t op_out
);
    import fm_mixer_pkg::*;

    localparam int LVL_W  = $bits(level_t);
    localparam int PROD_W = $bits(sine_t) + LVL_W;
    localparam int OPS_W  = PROD_W - 8;
    localparam int SUM_W  = 2 * LVL_W + $clog2(`FM_V_OSC);
    localparam int MODS_W = SUM_W - 6;
    localparam int MOD_W  = $bits(mod_t);

    level_t                   op_mem    [`FM_VOICES][`FM_V_OSC];
    level_t                   voice_ops [`FM_V_OSC];  // last frame's outputs, voice in flight
    logic signed [PROD_W-1:0] op_prod;
    logic signed [OPS_W-1:0]  op_shift;
    level_t                   op_sat;
    logic signed [SUM_W-1:0]  mod_sum;
    logic signed [MODS_W-1:0] mod_shift;
    mod_t                     mod_sat;
    logic                     vld_d1;

    assign op_prod  = sine_lut_out * level_mul_vel;
    assign op_shift = op_prod[PROD_W-1:8];  // >>> 8

    // clip operator output to the level range
    always_comb begin
        if (op_shift[OPS_W-1:LVL_W-1] == {(OPS_W-LVL_W+1){op_shift[OPS_W-1]}}) begin
            op_sat = op_shift[LVL_W-1:0];
        end else if (op_shift[OPS_W-1]) begin
            op_sat = {1'b1, {(LVL_W-1){1'b0}}};
        end else begin
            op_sat = {1'b0, {(LVL_W-1){1'b1}}};
        end
    end

    // row slot_d1.osc of the matrix, diagonal term is feedback
    always_comb begin
        mod_sum = '0;
        for (int s = 0; s < `FM_V_OSC; s++) begin
            mod_sum = mod_sum + route[slot_d1.osc * `FM_V_OSC + s] * voice_ops[s];
        end
    end

    assign mod_shift = mod_sum[SUM_W-1:6];

    always_comb begin
        if (mod_shift[MODS_W-1:MOD_W-1] == {(MODS_W-MOD_W+1){mod_shift[MODS_W-1]}}) begin
            mod_sat = mod_shift[MOD_W-1:0];
        end else if (mod_shift[MODS_W-1]) begin
            mod_sat = {1'b1, {(MOD_W-1){1'b0}}};
        end else begin
            mod_sat = {1'b0, {(MOD_W-1){1'b1}}};
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (!rst_n) begin
            op_out    <= '0;
            vld_d1    <= 1'b0;
            mod_valid <= 1'b0;
            for (int o = 0; o < `FM_V_OSC; o++) begin
                voice_ops[o] <= '0;
                for (int v = 0; v < `FM_VOICES; v++) begin
                    op_mem[v][o] <= '0;
                end
            end
        end else begin
            op_out    <= op_sat;     // stage 1
            vld_d1    <= 1'b1;
            mod_valid <= vld_d1;
            if (slot_now.osc == '0) begin
                voice_ops <= op_mem[slot_now.voice];  // snapshot before this frame overwrites
            end
            op_mem[slot_d1.voice][slot_d1.osc] <= op_out;  // stage 2
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        modulation <= mod_sat;
        mod_slot   <= slot_d1;
    end

endmodule

`default_nettype wire

/* hdl/vol_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fm_mixer_config.svh"

module vol_mixer (
    input  logic                 sCLK_XVXENVS,
    input  logic                 rst_n,
    input  fm_mixer_pkg::slot_t  slot_d1,
    input  logic                 frame_end_d2,
    input  fm_mixer_pkg::level_t op_out,
    input  fm_mixer_pkg::level_t osc_lvl [`FM_V_OSC],
    input  fm_mixer_pkg::level_t osc_pan [`FM_V_OSC],
    input  fm_mixer_pkg::level_t m_vol,
    output fm_mixer_pkg::audio_t lsound_out,
    output fm_mixer_pkg::audio_t rsound_out,
    output logic                 sound_valid
);
    import fm_mixer_pkg::*;

    localparam int LVL_W   = $bits(level_t);
    localparam int AUD_W   = $bits(audio_t);
    localparam int SLOT_PW = 2 * LVL_W;
    localparam int SLOT_W  = SLOT_PW - 7;
    localparam int SIDE_PW = SLOT_W + LVL_W;
    localparam int SIDE_W  = SIDE_PW - 7;
    localparam int ACC_W   = SIDE_W + $clog2(`FM_SLOTS);
    localparam int WIDE_W  = ACC_W + LVL_W + 1 + AUD_W;

    level_t                    lvl;
    level_t                    pan;
    level_t                    pan_inv;
    logic signed [SLOT_PW-1:0] slot_prod;
    logic signed [SLOT_W-1:0]  slot_val;
    logic signed [SIDE_PW-1:0] l_prod;
    logic signed [SIDE_PW-1:0] r_prod;
    logic signed [SIDE_W-1:0]  l_side;
    logic signed [SIDE_W-1:0]  r_side;
    logic signed [ACC_W-1:0]   acc_l;
    logic signed [ACC_W-1:0]   acc_r;
    logic signed [LVL_W:0]     vol_s;
    logic signed [WIDE_W-1:0]  l_mix;
    logic signed [WIDE_W-1:0]  r_mix;
    logic                      frame_first;

    function automatic audio_t sat_audio(input logic signed [WIDE_W-1:0] v);
        logic signed [WIDE_W-1:0] top;
        top = v >>> (AUD_W - 1);
        if (top == '0 || top == '1) begin
            return v[AUD_W-1:0];
        end else if (v[WIDE_W-1]) begin
            return {1'b1, {(AUD_W-1){1'b0}}};
        end
        return {1'b0, {(AUD_W-1){1'b1}}};
    endfunction

    assign lvl     = osc_lvl[slot_d1.osc];
    assign pan     = osc_pan[slot_d1.osc];
    assign pan_inv = 8'sd127 - pan;  // pan stored already clamped to 0..127

    assign slot_prod = op_out * lvl;
    assign slot_val  = slot_prod[SLOT_PW-1:7];
    assign l_prod    = slot_val * pan_inv;
    assign r_prod    = slot_val * pan;
    assign l_side    = l_prod[SIDE_PW-1:7];
    assign r_side    = r_prod[SIDE_PW-1:7];

    // master volume as unsigned
    assign vol_s = $signed({1'b0, m_vol});
    assign l_mix = acc_l * vol_s;
    assign r_mix = acc_r * vol_s;

    // slot 0 in stage 2 restarts the sums, also after a mid-frame restart
    assign frame_first = (slot_d1 == '0);

    always_ff @(posedge sCLK_XVXENVS) begin
        if (!rst_n) begin
            acc_l       <= '0;
            acc_r       <= '0;
            lsound_out  <= '0;
            rsound_out  <= '0;
            sound_valid <= 1'b0;
        end else begin
            sound_valid <= frame_end_d2;
            if (frame_end_d2) begin
                lsound_out <= sat_audio(l_mix >>> 7);  // acc still holds the whole frame
                rsound_out <= sat_audio(r_mix >>> 7);
            end
            if (frame_first) begin
                acc_l <= l_side;
                acc_r <= r_side;
            end else begin
                acc_l <= acc_l + l_side;
                acc_r <= acc_r + r_side;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/fm_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fm_mixer_config.svh"

module fm_mixer (
    input  logic                    sCLK_XVXENVS,
    input  logic                    rst_n,
    input  fm_mixer_pkg::host_bus_t host,
    output fm_mixer_pkg::level_t    rd_data,
    input  logic                    frame_start,
    input  fm_mixer_pkg::level_t    level_mul_vel,
    input  fm_mixer_pkg::sine_t     sine_lut_out,
    output fm_mixer_pkg::mod_t      modulation,
    output fm_mixer_pkg::slot_t     mod_slot,
    output logic                    mod_valid,
    output fm_mixer_pkg::audio_t    lsound_out,
    output fm_mixer_pkg::audio_t    rsound_out,
    output logic                    sound_valid
);
    import fm_mixer_pkg::*;

    level_t osc_lvl [`FM_V_OSC];
    level_t osc_pan [`FM_V_OSC];
    level_t route   [`FM_V_OSC*`FM_V_OSC];
    level_t m_vol;
    level_t op_out;   // stage-1 operator output
    slot_t  slot_now;
    slot_t  slot_d1;
    logic   frame_end_d2;

    patch_regs patch_regs_i (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .rst_n        (rst_n),
        .host         (host),
        .rd_data      (rd_data),
        .osc_lvl      (osc_lvl),
        .osc_pan      (osc_pan),
        .route        (route),
        .m_vol        (m_vol)
    );

    slot_sequencer slot_sequencer_i (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .rst_n        (rst_n),
        .frame_start  (frame_start),
        .slot_now     (slot_now),
        .slot_d1      (slot_d1),
        .slot_d2      (),              // mod_slot carries this index
        .frame_end_d2 (frame_end_d2)
    );

    modulation_matrix modulation_matrix_i (
        .sCLK_XVXENVS  (sCLK_XVXENVS),
        .rst_n         (rst_n),
        .slot_now      (slot_now),
        .slot_d1       (slot_d1),
        .level_mul_vel (level_mul_vel),
        .sine_lut_out  (sine_lut_out),
        .route         (route),
        .modulation    (modulation),
        .mod_slot      (mod_slot),
        .mod_valid     (mod_valid),
        .op_out        (op_out)
    );

    vol_mixer vol_mixer_i (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .rst_n        (rst_n),
        .slot_d1      (slot_d1),
        .frame_end_d2 (frame_end_d2),
        .op_out       (op_out),
        .osc_lvl      (osc_lvl),
        .osc_pan      (osc_pan),
        .m_vol        (m_vol),
        .lsound_out   (lsound_out),
        .rsound_out   (rsound_out),
        .sound_valid  (sound_valid)
    );

endmodule

`default_nettype wire

/* testbench/fm_mixer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fm_mixer_config.svh"

module fm_mixer_tb;
    import fm_mixer_pkg::*;

    localparam int DRAIN_MAX = `FM_SLOTS + 8;

    logic      sCLK_XVXENVS = 1'b0;
    logic      rst_n;
    host_bus_t host;
    level_t    rd_data;
    logic      frame_start;
    level_t    level_mul_vel;
    sine_t     sine_lut_out;
    mod_t      modulation;
    slot_t     mod_slot;
    logic      mod_valid;
    audio_t    lsound_out;
    audio_t    rsound_out;
    logic      sound_valid;

    // which slot the tb drives, delayed like the DUT pipeline
    logic drv_live = 1'b0;
    int   drv_slot = 0;
    logic live_d1  = 1'b0;
    logic live_d2  = 1'b0;
    logic live_d3  = 1'b0;
    int   slot_p1  = 0;
    int   slot_p2  = 0;
    int   slot_p3  = 0;

    int mod_exp     [`FM_SLOTS];
    bit mod_pending [`FM_SLOTS];
    int out_l_q [8];  // expected frame outputs, ring buffer
    int out_r_q [8];
    int out_wr = 0;
    int out_rd = 0;
    int lvl_v [`FM_SLOTS];
    int sin_v [`FM_SLOTS];

    int checks      = 0;
    int errors      = 0;
    int cycles      = 0;
    int cycle_limit = 0;
    int mon_slot;

    fm_mixer fm_mixer_i (
        .sCLK_XVXENVS  (sCLK_XVXENVS),
        .rst_n         (rst_n),
        .host          (host),
        .rd_data       (rd_data),
        .frame_start   (frame_start),
        .level_mul_vel (level_mul_vel),
        .sine_lut_out  (sine_lut_out),
        .modulation    (modulation),
        .mod_slot      (mod_slot),
        .mod_valid     (mod_valid),
        .lsound_out    (lsound_out),
        .rsound_out    (rsound_out),
        .sound_valid   (sound_valid)
    );

    always #4 sCLK_XVXENVS = ~sCLK_XVXENVS;  // 8 ns period

    always @(posedge sCLK_XVXENVS) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("run stopped, no progress within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    always @(posedge sCLK_XVXENVS) begin
        live_d1 <= drv_live;
        live_d2 <= live_d1;
        live_d3 <= live_d2;
        slot_p1 <= drv_slot;
        slot_p2 <= slot_p1;
        slot_p3 <= slot_p2;
    end

    task automatic check_value(input string name, input int expected, input int actual);
        checks = checks + 1;
        if (expected != actual) begin
            errors = errors + 1;
            $display("error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    // modulation two cycles after the slot inputs
    always @(negedge sCLK_XVXENVS) begin
        if (live_d2) begin
            check_value("mod_valid", 1, mod_valid);
            check_value("mod_slot", slot_p2, mod_slot);
            mon_slot = mod_slot;
            if (mod_pending[mon_slot]) begin
                check_value("modulation", mod_exp[mon_slot], modulation);
                mod_pending[mon_slot] = 1'b0;
            end
        end
    end

    // frame output three cycles after the last slot
    always @(negedge sCLK_XVXENVS) begin
        if (live_d3 && slot_p3 == `FM_SLOTS - 1) begin
            check_value("sound_valid", 1, sound_valid);
            if (out_rd != out_wr) begin
                check_value("lsound_out", out_l_q[out_rd % 8], lsound_out);
                check_value("rsound_out", out_r_q[out_rd % 8], rsound_out);
                out_rd = out_rd + 1;
            end
        end
    end

    function automatic int pending_left();
        int n;
        n = out_wr - out_rd;
        for (int s = 0; s < `FM_SLOTS; s++) begin
            if (mod_pending[s]) begin
                n = n + 1;
            end
        end
        return n;
    endfunction

    task automatic next_cycle();
        @(posedge sCLK_XVXENVS);
        #1;
    endtask

    task automatic drive_idle();
        frame_start   = 1'b0;
        level_mul_vel = '0;
        sine_lut_out  = '0;
        drv_live      = 1'b0;
        host.wr_stb   = 1'b0;
        host.rd_stb   = 1'b0;
    endtask

    task automatic write_reg(input int adr, input int data);
        next_cycle();
        drive_idle();
        host.adr     = adr[6:0];
        host.wr_data = data[7:0];
        host.wr_stb  = 1'b1;
        next_cycle();
        host.wr_stb = 1'b0;
    endtask

    task automatic read_reg(input int adr, input int expected);
        next_cycle();
        drive_idle();
        host.adr    = adr[6:0];
        host.rd_stb = 1'b1;
        @(posedge sCLK_XVXENVS);
        #1;
        host.rd_stb = 1'b0;
        @(negedge sCLK_XVXENVS);
        check_value("rd_data", expected, rd_data);
    endtask

    // full frame from lvl_v and sin_v, left driven after the last slot
    task automatic drive_frame();
        for (int i = 0; i < `FM_SLOTS; i++) begin
            next_cycle();
            host.wr_stb   = 1'b0;
            host.rd_stb   = 1'b0;
            frame_start   = (i == 0);
            level_mul_vel = lvl_v[i][7:0];
            sine_lut_out  = sin_v[i][16:0];
            drv_live      = 1'b1;
            drv_slot      = i;
        end
    endtask

    // slots that are cut off by the next frame_start, never checked
    task automatic drive_partial(input int n, input int lvl, input int sin);
        for (int i = 0; i < n; i++) begin
            next_cycle();
            drive_idle();
            frame_start   = (i == 0);
            level_mul_vel = lvl[7:0];
            sine_lut_out  = sin[16:0];
        end
    endtask

    task automatic finish_test(input logic [8*24-1:0] name, input int err_start);
        int waited;
        waited = 0;
        while ((pending_left() > 0 || drv_live || live_d1 || live_d2 || live_d3)
               && waited < DRAIN_MAX) begin
            next_cycle();
            drive_idle();
            waited = waited + 1;
        end
        for (int s = 0; s < `FM_SLOTS; s++) begin
            if (mod_pending[s]) begin
                $display("expected modulation for slot %0d never arrived", s);
                errors         = errors + 1;
                mod_pending[s] = 1'b0;
            end
        end
        if (out_rd != out_wr) begin
            $display("%0d expected stereo frame outputs never arrived", out_wr - out_rd);
            errors = errors + 1;
            out_rd = out_wr;
        end
        $display("test %0s: %0d errors", name, errors - err_start);
    endtask

    initial begin
        int               fd;
        int               c;
        int               n_lines;
        int               r;
        int               adr;
        int               val;
        int               a2;
        int               test_err0;
        bit               test_open;
        logic [8*24-1:0]  tok;
        logic [8*24-1:0]  test_name;

        rst_n         = 1'b0;
        host          = '0;
        frame_start   = 1'b0;
        level_mul_vel = '0;
        sine_lut_out  = '0;
        for (int s = 0; s < `FM_SLOTS; s++) begin
            mod_pending[s] = 1'b0;
            mod_exp[s]     = 0;
        end

        fd = $fopen("testbench/fm_mixer_trace.txt", "r");
        if (fd == 0) begin
            $display("trace file could not be opened");
            $display("Result: FAILED");
            $finish;
        end else begin
            n_lines = 0;
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == 10) begin
                    n_lines = n_lines + 1;
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
            fd = $fopen("testbench/fm_mixer_trace.txt", "r");
            cycle_limit = n_lines * `FM_SLOTS + 100;

            // reset held for 4 cycles, outputs must stay quiet
            repeat (3) begin
                @(posedge sCLK_XVXENVS);
                @(negedge sCLK_XVXENVS);
                check_value("mod_valid", 0, mod_valid);
                check_value("sound_valid", 0, sound_valid);
                check_value("rd_data", 0, rd_data);
            end
            @(posedge sCLK_XVXENVS);
            #1;
            rst_n = 1'b1;
            $display("test reset_hold: %0d errors", errors);

            test_open = 1'b0;
            test_err0 = errors;
            r = $fscanf(fd, "%s", tok);
            while (r == 1) begin
                if (tok == "#") begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if (tok == "T") begin
                    if (test_open) begin
                        finish_test(test_name, test_err0);
                    end
                    r         = $fscanf(fd, "%s", test_name);
                    test_open = 1'b1;
                    test_err0 = errors;
                end else if (tok == "W") begin
                    r = $fscanf(fd, "%h %d", adr, val);
                    write_reg(adr, val);
                end else if (tok == "R") begin
                    r = $fscanf(fd, "%h %d", adr, val);
                    read_reg(adr, val);
                end else if (tok == "M") begin
                    r = $fscanf(fd, "%d %d", adr, val);
                    mod_exp[adr]     = val;
                    mod_pending[adr] = 1'b1;
                end else if (tok == "O") begin
                    r = $fscanf(fd, "%d %d", adr, val);
                    out_l_q[out_wr % 8] = adr;
                    out_r_q[out_wr % 8] = val;
                    out_wr = out_wr + 1;
                end else if (tok == "S") begin
                    for (int i = 0; i < `FM_SLOTS; i++) begin
                        r = $fscanf(fd, "%d %d", lvl_v[i], sin_v[i]);
                    end
                    drive_frame();
                end else if (tok == "X") begin
                    r = $fscanf(fd, "%d %d %d", adr, val, a2);
                    drive_partial(adr, val, a2);
                end else begin
                    $display("unknown command in trace file");
                    errors = errors + 1;
                end
                r = $fscanf(fd, "%s", tok);
            end
            if (test_open) begin
                finish_test(test_name, test_err0);
            end
            $fclose(fd);

            $display("summary: %0d checks, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* fm_mixer.f */
+incdir+hdl
hdl/fm_mixer_pkg.sv
hdl/patch_regs.sv
hdl/slot_sequencer.sv
hdl/modulation_matrix.sv
hdl/vol_mixer.sv
hdl/fm_mixer.sv
testbench/fm_mixer_tb.sv

/* Bender.yml */
package:
  name: fm_mixer

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fm_mixer_pkg.sv
      - hdl/patch_regs.sv
      - hdl/slot_sequencer.sv
      - hdl/modulation_matrix.sv
      - hdl/vol_mixer.sv
      - hdl/fm_mixer.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/fm_mixer_tb.sv

/* testbench/fm_mixer_trace.txt */
# T name | W adr(hex) data | R adr(hex) expected | M slot modulation | O left right
# S then 16 pairs of level and sine, slot 0 first | X count level sine; M and O queue ahead
T reset_read
R 00 0
R 20 0
T zero_route
M 0 0
M 5 0
M 10 0
M 15 0
O 0 0
S 1 2560 1 2560 1 2560 1 2560 1 2560 1 2560 1 2560 1 2560
  1 2560 1 2560 1 2560 1 2560 1 2560 1 2560 1 2560 1 2560
T regs
W 00 127
W 01 127
W 02 64
W 08 0
W 09 200
W 0A 64
W 20 127
W 13 -77
R 00 127
R 02 64
R 09 127
R 0A 64
R 13 -77
R 20 127
R 05 0
R 40 0
T routing
W 14 64
W 15 16
W 18 -128
W 19 -128
W 1A -128
W 1B -128
S 1 2560 1 -5120 0 0 0 0 1 -32768 1 -32768 1 -32768 1 -32768
  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
M 0 0
M 1 5
M 2 20
M 4 154
M 5 -160
M 6 1023
S 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
T stereo
O 97 0
S 1 25600 0 0 0 0 0 0 0 0 0 0 0 0 0 0
  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
O 0 -2
S 0 0 1 25600 0 0 0 0 0 0 0 0 0 0 0 0
  0 0 1 -25600 0 0 0 0 0 0 0 0 0 0 0 0
O 23 24
S 0 0 0 0 1 25600 0 0 0 0 0 0 0 0 0 0
  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
O -632 -632
S 1 -32768 1 -32768 1 -32768 1 -32768 1 -32768 1 -32768 1 -32768 1 -32768
  1 -32768 1 -32768 1 -32768 1 -32768 1 -32768 1 -32768 1 -32768 1 -32768
T back_to_back
O 97 0
O 23 24
X 5 1 25600
S 1 25600 0 0 0 0 0 0 0 0 0 0 0 0 0 0
  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
S 0 0 0 0 1 25600 0 0 0 0 0 0 0 0 0 0
  0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
